/* logic/decode_settings.svh */
// Widths and constants shared by the decode stage and its testbench
// SYSCALL_DRAIN has to fit in the 2-bit drain counter of the sequencer

`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath widths
`define DATA_WIDTH       32
`define REG_COUNT        32
`define REG_INDEX_WIDTH  5
`define ALU_OP_WIDTH     6

// Fixed registers
`define LINK_REG         31  // JAL destination
`define SYSCALL_ARG_REG  2   // Syscall argument, read through port A

// Sequencing and link constants
`define SYSCALL_DRAIN    3   // Bubbles before a syscall issues
`define LINK_OFFSET      4   // Added to pcPlus4 in EX to form the link value

`endif

/* logic/decodePkg.sv */
// Types of the decode stage
// The ALU codes are local to this pipeline and not the MIPS funct values

`include "decode_settings.svh"

package decodePkg;

	typedef logic [`DATA_WIDTH-1:0] dataWord_t;
	typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluSllv,
		aluSrlv,
		aluSrav,
		aluLui,
		aluPassA  // Branch compare and jumps, result unused
	} aluOp_e;

	// Control half of the ID/EX register, all zero is a bubble
	typedef struct packed {
		logic                        valid;
		logic                        sysIssue;
		aluOp_e                      aluOp;
		regIndex_t                   destReg;
		logic [`REG_INDEX_WIDTH-1:0] shamt;
		logic                        writeBack;
		logic                        memRead;
		logic                        memWrite;
		logic                        memToReg;
		logic                        takenBranch;
	} ctrlBundle_t;

	// Data half of the ID/EX register
	typedef struct packed {
		dataWord_t opA;
		dataWord_t opB;
		dataWord_t nextPc;
	} operandBundle_t;

endpackage

/* logic/instrDecoder.sv */
// Word loads and stores only, no coprocessor, HI/LO or likely branches
// Unknown encodings drop legal, the top level turns them into bubbles

`timescale 1ns/1ps
`include "decode_settings.svh"

module instrDecoder (
	input  decodePkg::dataWord_t   instr,
	output decodePkg::ctrlBundle_t ctrl,
	output decodePkg::dataWord_t   imm,
	output logic                   useImm,
	output logic                   isJump,
	output logic                   isJumpReg,
	output logic                   isBranch,
	output logic                   isLink,
	output logic                   isSyscall,
	output logic                   legal
);
	import decodePkg::*;

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opRegImm  = 6'h01;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opBlez    = 6'h06;
	localparam logic [5:0] opBgtz    = 6'h07;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opSlti    = 6'h0a;
	localparam logic [5:0] opSltiu   = 6'h0b;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opXori    = 6'h0e;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	logic [5:0] opcode;
	logic [5:0] funct;
	regIndex_t  rt;
	regIndex_t  rd;
	aluOp_e     aluOp;
	regIndex_t  destReg;
	logic       rType;     // Destination from rd
	logic       regWrite;
	logic       isLoad;
	logic       isStore;
	logic       zeroExt;

	assign opcode = instr[31:26];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];

	always_comb begin
		aluOp     = aluAdd;  // Link and syscall add in EX
		rType     = 1'b0;
		regWrite  = 1'b0;
		isLoad    = 1'b0;
		isStore   = 1'b0;
		zeroExt   = 1'b0;
		useImm    = 1'b0;
		isJump    = 1'b0;
		isJumpReg = 1'b0;
		isBranch  = 1'b0;
		isLink    = 1'b0;
		isSyscall = 1'b0;
		legal     = 1'b1;
		case (opcode)
			opSpecial: begin
				rType    = 1'b1;
				regWrite = 1'b1;
				case (funct)
					6'h00: aluOp = aluSll;
					6'h02: aluOp = aluSrl;
					6'h03: aluOp = aluSra;
					6'h04: aluOp = aluSllv;
					6'h06: aluOp = aluSrlv;
					6'h07: aluOp = aluSrav;
					6'h08: begin // JR
						aluOp     = aluPassA;
						regWrite  = 1'b0;
						isJump    = 1'b1;
						isJumpReg = 1'b1;
					end
					6'h0c: begin
						regWrite  = 1'b0;
						isSyscall = 1'b1;
					end
					6'h20: aluOp = aluAdd;
					6'h21: aluOp = aluAddu;
					6'h22: aluOp = aluSub;
					6'h23: aluOp = aluSubu;
					6'h24: aluOp = aluAnd;
					6'h25: aluOp = aluOr;
					6'h26: aluOp = aluXor;
					6'h27: aluOp = aluNor;
					6'h2a: aluOp = aluSlt;
					6'h2b: aluOp = aluSltu;
					default: begin
						regWrite = 1'b0;
						legal    = 1'b0;
					end
				endcase
			end
			opRegImm: begin
				aluOp    = aluPassA;
				isBranch = 1'b1;
				legal    = (rt == 5'd0) || (rt == 5'd1);  // BLTZ, BGEZ
			end
			opJ: begin
				aluOp  = aluPassA;
				isJump = 1'b1;
			end
			opJal: begin
				isJump   = 1'b1;
				isLink   = 1'b1;
				regWrite = 1'b1;
			end
			opBeq, opBne: begin
				aluOp    = aluSub;
				isBranch = 1'b1;
			end
			opBlez, opBgtz: begin
				aluOp    = aluPassA;
				isBranch = 1'b1;
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				zeroExt  = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
				case (opcode)
					opAddi:  aluOp = aluAdd;
					opAddiu: aluOp = aluAddu;
					opSlti:  aluOp = aluSlt;
					opSltiu: aluOp = aluSltu;
					opAndi:  aluOp = aluAnd;
					opOri:   aluOp = aluOr;
					opXori:  aluOp = aluXor;
					default: aluOp = aluLui;
				endcase
			end
			opLw: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				isLoad   = 1'b1;
			end
			opSw: begin
				useImm  = 1'b1;
				isStore = 1'b1;
			end
			default: legal = 1'b0;
		endcase

		if (isLink)
			destReg = regIndex_t'(`LINK_REG);
		else if (isSyscall)
			destReg = '0;
		else
			destReg = rType ? rd : rt;

		ctrl             = '0;
		ctrl.valid       = legal;
		ctrl.sysIssue    = isSyscall;
		ctrl.aluOp       = aluOp;
		ctrl.destReg     = destReg;
		ctrl.shamt       = instr[10:6];
		ctrl.writeBack   = (regWrite && (destReg != '0)) || isLoad;
		ctrl.memRead     = isLoad;
		ctrl.memWrite    = isStore;
		ctrl.memToReg    = isLoad;
		ctrl.takenBranch = 1'b0;  // Filled in by the top level
	end

	assign imm = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

/* logic/registerFile.sv */
// Two combinational reads, one write on the clock edge
// A same-cycle read returns the old word, the WB bypass covers it

`timescale 1ns/1ps
`include "decode_settings.svh"

module registerFile (
	input  logic                 CLK,
	input  logic                 RESET,
	input  decodePkg::regIndex_t readA,
	input  decodePkg::regIndex_t readB,
	output decodePkg::dataWord_t dataA,
	output decodePkg::dataWord_t dataB,
	input  logic                 writeEn,
	input  decodePkg::regIndex_t writeReg,
	input  decodePkg::dataWord_t writeData
);
	import decodePkg::*;

	dataWord_t regs [`REG_COUNT];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEn && (writeReg != '0)) begin  // r0 stays zero
			regs[writeReg] <= writeData;
		end
	end

	assign dataA = (readA == '0) ? '0 : regs[readA];
	assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

/* logic/operandForward.sv */
// Bypass from EX, MEM and WB with the youngest result winning
// Results aimed at register 0 never forward

`timescale 1ns/1ps

module operandForward (
	input  decodePkg::regIndex_t readA,
	input  decodePkg::regIndex_t readB,
	input  decodePkg::dataWord_t dataA,
	input  decodePkg::dataWord_t dataB,
	input  decodePkg::dataWord_t imm,
	input  logic                 useImm,
	input  logic                 exWriteBack,
	input  decodePkg::regIndex_t exReg,
	input  decodePkg::dataWord_t exData,
	input  logic                 memWriteBack,
	input  decodePkg::regIndex_t memReg,
	input  decodePkg::dataWord_t memData,
	input  logic                 wbWriteBack,
	input  decodePkg::regIndex_t wbReg,
	input  decodePkg::dataWord_t wbData,
	output decodePkg::dataWord_t fwdA,
	output decodePkg::dataWord_t fwdB,
	output decodePkg::dataWord_t opB
);
	import decodePkg::*;

	// Same priority chain for both read ports
	function automatic dataWord_t bypass(input regIndex_t src, input dataWord_t regVal);
		dataWord_t result;
		result = regVal;
		if (src != '0) begin
			if (exWriteBack && (exReg == src))
				result = exData;
			else if (memWriteBack && (memReg == src))
				result = memData;
			else if (wbWriteBack && (wbReg == src))
				result = wbData;
		end
		return result;
	endfunction

	always_comb begin
		fwdA = bypass(readA, dataA);
		fwdB = bypass(readB, dataB);
		opB  = useImm ? imm : fwdB;  // Immediate ops, loads, stores
	end

endmodule

/* logic/branchResolve.sv */
// Branches resolve here in ID against forwarded operands
// Jump targets take their upper bits from pcPlus4

`timescale 1ns/1ps

module branchResolve (
	input  decodePkg::dataWord_t instr,
	input  decodePkg::dataWord_t pcPlus4,
	input  decodePkg::dataWord_t imm,
	input  decodePkg::dataWord_t fwdA,
	input  decodePkg::dataWord_t fwdB,
	input  logic                 isBranch,
	input  logic                 isJump,
	input  logic                 isJumpReg,
	output logic                 takenBranch,
	output decodePkg::dataWord_t nextPc
);
	import decodePkg::*;

	logic      condMet;
	dataWord_t jumpTarget;
	dataWord_t branchTarget;

	always_comb begin
		case (instr[31:26])
			6'h04: condMet = (fwdA == fwdB);                   // BEQ
			6'h05: condMet = (fwdA != fwdB);                   // BNE
			6'h06: condMet = ($signed(fwdA) <= 0);             // BLEZ
			6'h07: condMet = ($signed(fwdA) > 0);              // BGTZ
			6'h01: condMet = instr[16] ? !fwdA[31] : fwdA[31]; // BGEZ or BLTZ
			default: condMet = 1'b0;
		endcase
	end

	assign takenBranch = isBranch && condMet;

	assign jumpTarget   = isJumpReg ? fwdA : {pcPlus4[31:28], instr[25:0], 2'b00};
	assign branchTarget = pcPlus4 + (imm << 2);

	// Jumps first, then taken branches, else fall through
	always_comb begin
		if (isJump)
			nextPc = jumpTarget;
		else if (takenBranch)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

endmodule

/* logic/syscallSequencer.sv */
// Holds a syscall in ID for SYSCALL_DRAIN unfrozen cycles
// isSyscall must already be qualified by instrValid

`timescale 1ns/1ps
`include "decode_settings.svh"

module syscallSequencer (
	input  logic CLK,
	input  logic RESET,
	input  logic freeze,
	input  logic isSyscall,
	output logic syscallStall
);

	typedef enum logic {seqIdle, seqDrain} seqState_e;

	seqState_e  state;
	logic [1:0] drainCount;

	assign syscallStall = isSyscall && (drainCount != '0);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			state      <= seqIdle;
			drainCount <= 2'(`SYSCALL_DRAIN);
		end else if (!freeze) begin
			case (state)
				seqIdle: begin
					if (isSyscall) begin  // First bubble
						state      <= seqDrain;
						drainCount <= drainCount - 2'd1;
					end
				end
				default: begin
					// Consumed at zero, or the syscall went away
					if (!isSyscall || (drainCount == '0)) begin
						state      <= seqIdle;
						drainCount <= 2'(`SYSCALL_DRAIN);
					end else begin
						drainCount <= drainCount - 2'd1;
					end
				end
			endcase
		end
	end

endmodule

/* logic/stageRegister.sv */
// One pipeline register for any packed payload
// Freeze wins over bubble, a bubble loads all zeros

`timescale 1ns/1ps

module stageRegister #(
	parameter type payload_t = decodePkg::ctrlBundle_t
) (
	input  logic     CLK,
	input  logic     RESET,
	input  logic     freeze,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET)
			q <= '0;
		else if (!freeze)
			q <= bubble ? payload_t'('0) : d;
	end

endmodule

/* logic/decodeStage.sv */
// ID stage of a single-issue pipeline, all outputs but syscallStall registered
// Upstream holds instr and pcPlus4 while freeze or syscallStall is high

`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeStage (
	input  logic                 CLK,
	input  logic                 RESET,
	input  decodePkg::dataWord_t instr,
	input  decodePkg::dataWord_t pcPlus4,
	input  logic                 instrValid,
	input  logic                 freeze,
	input  logic                 exWriteBack,
	input  decodePkg::regIndex_t exReg,
	input  decodePkg::dataWord_t exData,
	input  logic                 memWriteBack,
	input  decodePkg::regIndex_t memReg,
	input  decodePkg::dataWord_t memData,
	input  logic                 wbWriteBack,
	input  decodePkg::regIndex_t wbReg,
	input  decodePkg::dataWord_t wbData,
	output logic                 outValid,
	output logic                 sysIssue,
	output decodePkg::aluOp_e    aluOp,
	output logic [`REG_INDEX_WIDTH-1:0] shamt,
	output decodePkg::regIndex_t destReg,
	output logic                 writeBack,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 memToReg,
	output logic                 takenBranch,
	output decodePkg::dataWord_t opA,
	output decodePkg::dataWord_t opB,
	output decodePkg::dataWord_t nextPc,
	output logic                 syscallStall
);
	import decodePkg::*;

	ctrlBundle_t    ctrl, ctrlD, ctrlQ;
	operandBundle_t operD, operQ;
	dataWord_t      imm, dataA, dataB, fwdA, fwdB, opBFwd, nextPcD;
	regIndex_t      readA;
	logic           useImm, isJump, isJumpReg, isBranch, isLink, isSyscall, legal;
	logic           branchTaken;
	logic           consumed;

	//////////////////////////////////////////////////////////////////////
	// Decode, register read and bypass
	//////////////////////////////////////////////////////////////////////

	instrDecoder decoder (.instr, .ctrl, .imm, .useImm, .isJump, .isJumpReg,
		.isBranch, .isLink, .isSyscall, .legal);

	assign readA = isSyscall ? regIndex_t'(`SYSCALL_ARG_REG) : instr[25:21];

	// WB writes hold with the rest of the stage while frozen
	registerFile regFile (.CLK, .RESET, .readA, .readB(instr[20:16]), .dataA, .dataB,
		.writeEn(wbWriteBack && !freeze), .writeReg(wbReg), .writeData(wbData));

	operandForward forward (.readA, .readB(instr[20:16]), .dataA, .dataB, .imm, .useImm,
		.exWriteBack, .exReg, .exData, .memWriteBack, .memReg, .memData,
		.wbWriteBack, .wbReg, .wbData, .fwdA, .fwdB, .opB(opBFwd));

	branchResolve branch (.instr, .pcPlus4, .imm, .fwdA, .fwdB, .isBranch, .isJump,
		.isJumpReg, .takenBranch(branchTaken), .nextPc(nextPcD));

	syscallSequencer sequencer (.CLK, .RESET, .freeze,
		.isSyscall(isSyscall && instrValid), .syscallStall);

	//////////////////////////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////////////////////////

	assign consumed = instrValid && legal && !syscallStall;

	always_comb begin
		ctrlD             = ctrl;
		ctrlD.takenBranch = branchTaken;
		operD.opA         = isLink ? pcPlus4 : fwdA;  // Link value formed in EX
		if (isLink)
			operD.opB = dataWord_t'(`LINK_OFFSET);
		else if (isSyscall)
			operD.opB = '0;
		else
			operD.opB = opBFwd;
		operD.nextPc = nextPcD;
	end

	stageRegister #(.payload_t(ctrlBundle_t)) ctrlReg (.CLK, .RESET, .freeze,
		.bubble(!consumed), .d(ctrlD), .q(ctrlQ));

	stageRegister #(.payload_t(operandBundle_t)) operReg (.CLK, .RESET, .freeze,
		.bubble(!consumed), .d(operD), .q(operQ));

	assign outValid    = ctrlQ.valid;
	assign sysIssue    = ctrlQ.sysIssue;
	assign aluOp       = ctrlQ.aluOp;
	assign shamt       = ctrlQ.shamt;
	assign destReg     = ctrlQ.destReg;
	assign writeBack   = ctrlQ.writeBack;
	assign memRead     = ctrlQ.memRead;
	assign memWrite    = ctrlQ.memWrite;
	assign memToReg    = ctrlQ.memToReg;
	assign takenBranch = ctrlQ.takenBranch;
	assign opA         = operQ.opA;
	assign opB         = operQ.opB;
	assign nextPc      = operQ.nextPc;

endmodule

/* tests/decodeStageTb.sv */
// Random instructions from a fixed seed checked against a model of the stage
// Source and forwarding registers stay within r0 to r7 so that bypasses hit often

`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeStageTb;
	import decodePkg::*;

	localparam int numCycles = 3000;
	localparam int clkPeriod = 40;
	localparam logic [5:0] aluFuncts [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	localparam aluOp_e immAluOps [8] = '{aluAdd, aluAddu, aluSlt, aluSltu,
		aluAnd, aluOr, aluXor, aluLui};

	logic                        CLK, RESET;
	dataWord_t                   instr, pcPlus4;
	logic                        instrValid, freeze;
	logic                        exWriteBack, memWriteBack, wbWriteBack;
	regIndex_t                   exReg, memReg, wbReg;
	dataWord_t                   exData, memData, wbData;
	logic                        outValid, sysIssue, writeBack, memRead, memWrite;
	logic                        memToReg, takenBranch, syscallStall;
	aluOp_e                      aluOp;
	logic [`REG_INDEX_WIDTH-1:0] shamt;
	regIndex_t                   destReg;
	dataWord_t                   opA, opB, nextPc;

	// Model state
	logic [31:0]    rngState;
	dataWord_t      modelRegs [`REG_COUNT];
	int             drainLeft;
	int             freezeLeft;
	logic           holdInstr;
	ctrlBundle_t    predCtrl, expCtrl;
	operandBundle_t predOper, expOper;
	logic           predLegal, predSys, predStall, consumedNow;
	logic           expFull;     // Set when a real instruction was loaded

	decodeStage DUT (.*);

	always #(clkPeriod / 2) CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// Random numbers and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input dataWord_t expected,
		input dataWord_t actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkReg(input string name, input regIndex_t expected,
		input regIndex_t actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkAlu(input string name, input aluOp_e expected, input aluOp_e actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %s, got %s (%0d)", $time, name,
				expected.name(), actual.name(), actual);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			abortRun();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Youngest in-flight result wins and r0 never forwards
	function automatic dataWord_t forwarded(input regIndex_t src);
		if (src == '0)
			return '0;
		if (exWriteBack && (exReg == src))
			return exData;
		if (memWriteBack && (memReg == src))
			return memData;
		if (wbWriteBack && (wbReg == src))
			return wbData;
		return modelRegs[src];
	endfunction

	task automatic decodeModel();
		logic [5:0] opcode;
		regIndex_t  rt;
		regIndex_t  dest;
		aluOp_e     alu;
		dataWord_t  immVal;
		dataWord_t  valA;
		dataWord_t  valB;
		logic       regWrite;
		logic       isLoad;
		logic       isStore;
		logic       useImm;
		logic       zeroExt;
		logic       isLink;
		logic       isJump;
		logic       isBranch;
		logic       condMet;
		opcode    = instr[31:26];
		rt        = instr[20:16];
		dest      = rt;
		alu       = aluAdd;
		regWrite  = 1'b0;
		isLoad    = 1'b0;
		isStore   = 1'b0;
		useImm    = 1'b0;
		zeroExt   = 1'b0;
		isLink    = 1'b0;
		isJump    = 1'b0;
		isBranch  = 1'b0;
		predLegal = 1'b1;
		predSys   = 1'b0;
		case (opcode)
			6'h00: begin
				dest     = instr[15:11];
				regWrite = 1'b1;
				case (instr[5:0])
					6'h00: alu = aluSll;
					6'h02: alu = aluSrl;
					6'h03: alu = aluSra;
					6'h04: alu = aluSllv;
					6'h06: alu = aluSrlv;
					6'h07: alu = aluSrav;
					6'h20: alu = aluAdd;
					6'h21: alu = aluAddu;
					6'h22: alu = aluSub;
					6'h23: alu = aluSubu;
					6'h24: alu = aluAnd;
					6'h25: alu = aluOr;
					6'h26: alu = aluXor;
					6'h27: alu = aluNor;
					6'h2a: alu = aluSlt;
					6'h2b: alu = aluSltu;
					6'h08: begin // JR
						alu      = aluPassA;
						regWrite = 1'b0;
						isJump   = 1'b1;
					end
					6'h0c: begin
						regWrite = 1'b0;
						predSys  = 1'b1;
						dest     = '0;
					end
					default: begin
						regWrite  = 1'b0;
						predLegal = 1'b0;
					end
				endcase
			end
			6'h01: begin
				alu       = aluPassA;
				isBranch  = 1'b1;
				predLegal = (rt == 5'd0) || (rt == 5'd1);
			end
			6'h02: begin
				alu    = aluPassA;
				isJump = 1'b1;
			end
			6'h03: begin
				isJump   = 1'b1;
				isLink   = 1'b1;
				regWrite = 1'b1;
				dest     = regIndex_t'(`LINK_REG);
			end
			6'h04, 6'h05: begin
				alu      = aluSub;
				isBranch = 1'b1;
			end
			6'h06, 6'h07: begin
				alu      = aluPassA;
				isBranch = 1'b1;
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				alu      = immAluOps[opcode[2:0]];
				zeroExt  = (opcode == 6'h0c) || (opcode == 6'h0d) || (opcode == 6'h0e);
			end
			6'h23: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				isLoad   = 1'b1;
			end
			6'h2b: begin
				useImm  = 1'b1;
				isStore = 1'b1;
			end
			default: predLegal = 1'b0;
		endcase

		immVal = zeroExt ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
		valA   = forwarded(predSys ? regIndex_t'(`SYSCALL_ARG_REG) : instr[25:21]);
		valB   = forwarded(rt);
		case (opcode)
			6'h04: condMet = (valA == valB);
			6'h05: condMet = (valA != valB);
			6'h06: condMet = ($signed(valA) <= 0);
			6'h07: condMet = ($signed(valA) > 0);
			6'h01: condMet = (rt == 5'd1) ? !valA[31] : valA[31];  // BGEZ else BLTZ
			default: condMet = 1'b0;
		endcase

		predCtrl             = '0;
		predCtrl.valid       = predLegal;
		predCtrl.sysIssue    = predSys;
		predCtrl.aluOp       = alu;
		predCtrl.destReg     = dest;
		predCtrl.shamt       = instr[10:6];
		predCtrl.writeBack   = (regWrite && (dest != '0)) || isLoad;
		predCtrl.memRead     = isLoad;
		predCtrl.memWrite    = isStore;
		predCtrl.memToReg    = isLoad;
		predCtrl.takenBranch = isBranch && condMet;

		predOper.opA = isLink ? pcPlus4 : valA;
		if (isLink)
			predOper.opB = `LINK_OFFSET;
		else if (predSys)
			predOper.opB = '0;
		else
			predOper.opB = useImm ? immVal : valB;
		if (isJump)
			predOper.nextPc = (opcode == 6'h00) ? valA : {pcPlus4[31:28], instr[25:0], 2'b00};
		else if (predCtrl.takenBranch)
			predOper.nextPc = pcPlus4 + (immVal << 2);
		else
			predOper.nextPc = pcPlus4;
	endtask

	// Runs once the inputs of a cycle have settled
	task automatic predictCycle();
		decodeModel();
		predStall   = instrValid && predSys && (drainLeft != 0);
		consumedNow = instrValid && predLegal && !predStall;
		checkBit("syscallStall", predStall, syscallStall);
	endtask

	// Runs right after the rising edge on the inputs of the cycle that ended
	task automatic advanceModel();
		if (!freeze) begin
			if (wbWriteBack && (wbReg != '0))
				modelRegs[wbReg] = wbData;
			if (consumedNow) begin
				expCtrl = predCtrl;
				expOper = predOper;
				expFull = 1'b1;
			end else begin
				expCtrl = '0;
				expOper = '0;
				expFull = 1'b0;
			end
			if (instrValid && predSys && (drainLeft != 0))
				drainLeft--;
			else
				drainLeft = `SYSCALL_DRAIN;
		end
		holdInstr = freeze || predStall;  // Upstream holds the instruction
	endtask

	task automatic checkOutputs();
		checkBit("outValid", expCtrl.valid, outValid);
		checkBit("sysIssue", expCtrl.sysIssue, sysIssue);
		checkBit("writeBack", expCtrl.writeBack, writeBack);
		checkBit("memRead", expCtrl.memRead, memRead);
		checkBit("memWrite", expCtrl.memWrite, memWrite);
		checkBit("takenBranch", expCtrl.takenBranch, takenBranch);
		if (expFull) begin
			checkAlu("aluOp", expCtrl.aluOp, aluOp);
			checkReg("destReg", expCtrl.destReg, destReg);
			checkReg("shamt", expCtrl.shamt, shamt);
			checkBit("memToReg", expCtrl.memToReg, memToReg);
			checkWord("opA", expOper.opA, opA);
			checkWord("opB", expOper.opB, opB);
			checkWord("nextPc", expOper.nextPc, nextPc);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic pickInstr();
		logic [31:0] r;
		logic [31:0] k;
		regIndex_t   rs;
		regIndex_t   rt;
		r  = nextRandom();
		k  = nextRandom();
		rs = {2'b00, r[2:0]};
		rt = {2'b00, r[5:3]};
		case (k[3:0])
			4'd4, 4'd5: instr = {3'b001, k[6:4], rs, rt, r[31:16]};  // Immediate ALU
			4'd6: instr = {6'h23, rs, rt, r[31:16]};
			4'd7: instr = {6'h2b, rs, rt, r[31:16]};
			4'd8, 4'd9: instr = {4'b0001, k[5:4], rs, rt, r[31:16]};  // BEQ to BGTZ
			4'd10: instr = {6'h01, rs, 4'b0000, k[4], r[31:16]};
			4'd11: instr = {5'b00001, k[4], r[31:6]};                 // J or JAL
			4'd12: instr = {6'h00, rs, rt, r[15:6], 6'h08};
			4'd13: instr = {6'h00, r[31:12], 6'h0c};
			4'd14: begin
				// Encodings outside the kept set
				case (k[5:4])
					2'd0: instr = {6'h3f, r[25:0]};
					2'd1: instr = {6'h00, rs, rt, r[15:6], 6'h3e};
					2'd2: instr = {6'h01, rs, 5'd3, r[15:0]};
					default: instr = {6'h10, r[25:0]};
				endcase
			end
			default: instr = {6'h00, rs, rt, r[15:6], aluFuncts[k[7:4]]};
		endcase
	endtask

	task automatic driveInputs();
		logic [31:0] r;
		r            = nextRandom();
		exWriteBack  = r[0];
		exReg        = {2'b00, r[3:1]};
		memWriteBack = r[4];
		memReg       = {2'b00, r[7:5]};
		wbWriteBack  = r[8];
		wbReg        = {2'b00, r[11:9]};
		exData       = nextRandom();
		memData      = nextRandom();
		wbData       = nextRandom();
		if ((freezeLeft == 0) && (r[14:12] == 3'd0))
			freezeLeft = 1 + r[16:15];  // 1 to 4 frozen cycles
		freeze = (freezeLeft != 0);
		if (freezeLeft != 0)
			freezeLeft--;
		if (!holdInstr) begin
			pickInstr();
			instrValid = (r[19:17] != 3'd0);
			pcPlus4    = nextRandom() & ~32'h3;
		end
	endtask

	initial begin
		rngState     = 32'h5164;
		CLK          = 1'b0;
		RESET        = 1'b0;
		instr        = '0;
		pcPlus4      = '0;
		instrValid   = 1'b0;
		freeze       = 1'b0;
		exWriteBack  = 1'b0;
		exReg        = '0;
		exData       = '0;
		memWriteBack = 1'b0;
		memReg       = '0;
		memData      = '0;
		wbWriteBack  = 1'b0;
		wbReg        = '0;
		wbData       = '0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		drainLeft  = `SYSCALL_DRAIN;
		freezeLeft = 0;
		holdInstr  = 1'b0;
		expCtrl    = '0;
		expOper    = '0;
		expFull    = 1'b0;

		repeat (3) @(posedge CLK);
		#2 RESET = 1'b1;
		#1 checkOutputs();  // Everything low out of reset
		predictCycle();

		for (int cycle = 0; cycle < numCycles; cycle++) begin
			@(posedge CLK);
			advanceModel();
			#1 checkOutputs();
			#1 driveInputs();
			#1 predictCycle();
		end

		$display("All tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		#((numCycles + 50) * clkPeriod);
		$display("Timeout: the test loop did not finish in the expected time");
		abortRun();
	end

endmodule

/* src.f */
+incdir+logic
logic/decodePkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/operandForward.sv
logic/branchResolve.sv
logic/syscallSequencer.sv
logic/stageRegister.sv
logic/decodeStage.sv
tests/decodeStageTb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 -f src.f --top-module decodeStageTb -o decodeStageSim; then
	echo "Verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/decodeStageSim 2>&1)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "All tests passed" <<< "$simOutput"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
